/* project.f */
source/soc_cfg_pkg.sv
source/mem_bus_pkg.sv
source/mem_port_if.sv
source/req_ack_port.sv
source/dualport_ram.sv
source/soc_mem_top.sv
test/tb_soc_mem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_soc_mem
FILELIST  := project.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary -j 0 --Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only --timing
PASS_MSG  := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_soc_mem.sv */
`timescale 1ns/1ps

module tb_soc_mem;

    import soc_cfg_pkg::*;
    import mem_bus_pkg::*;

    ////////////////////////////////////////////////////////////
    // run length and watchdog limit
    ////////////////////////////////////////////////////////////

    localparam int n_random = 300;
    localparam int n_burst  = 40;
    // fill writes, then readback, random, bursts and final sweep
    localparam int n_init   = mem_depth;
    localparam int n_txn    = 2 * mem_depth + 2 * n_random + 2 * n_burst;
    localparam int timeout_cycles = (n_init + n_txn) * 8 + 100;

    logic  clk;
    logic  rst;

    // requester side
    // index 0 is channel a and 1 is channel b
    logic  req   [2];
    logic  we    [2];
    addr_t addr  [2];
    word_t wdata [2];
    mask_t wmask [2];

    logic  a_ack;
    logic  b_ack;
    word_t a_rdata;
    word_t b_rdata;

    // reference memory and per-channel pending access
    word_t    model_mem [mem_depth];
    word_t    fill_data [mem_depth];
    logic     pend      [2];
    int       pend_edge [2];
    mem_req_t pend_req  [2];
    logic     do_acc    [2];
    logic     req_seen  [2];
    // old word per channel as of its access edge
    word_t    exp_old   [2];

    int cycle          = 0;
    int checks         = 0;
    int word_errors    = 0;
    int latency_errors = 0;
    int proto_errors   = 0;

    soc_mem_top dut (
        .clk     (clk),
        .rst     (rst),
        .a_req   (req[0]),
        .a_we    (we[0]),
        .a_addr  (addr[0]),
        .a_wdata (wdata[0]),
        .a_wmask (wmask[0]),
        .a_ack   (a_ack),
        .a_rdata (a_rdata),
        .b_req   (req[1]),
        .b_we    (we[1]),
        .b_addr  (addr[1]),
        .b_wdata (wdata[1]),
        .b_wmask (wmask[1]),
        .b_ack   (b_ack),
        .b_rdata (b_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // cycle count and watchdog
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles) begin
            $display("ERROR run stopped at %0d cycles, a channel never finished", cycle);
            $display("*** FAILED ***");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers and compare tasks
    ////////////////////////////////////////////////////////////

    function automatic logic ack_of(input int ch);
        return (ch == 0) ? a_ack : b_ack;
    endfunction

    function automatic word_t rdata_of(input int ch);
        return (ch == 0) ? a_rdata : b_rdata;
    endfunction

    // bytes under the mask take the new data
    function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                          input mask_t mask);
        word_t result;
        result = old_word;
        for (int i = 0; i < mask_width; i++) begin
            if (mask[i]) begin
                result[i*byte_width +: byte_width] = new_word[i*byte_width +: byte_width];
            end
        end
        return result;
    endfunction

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            word_errors++;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            latency_errors++;
            $display("FAIL %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model and protocol monitor
    ////////////////////////////////////////////////////////////

    // steps on falling edges between driven edges
    always @(negedge clk) begin
        if (!rst) begin
            for (int ch = 0; ch < 2; ch++) begin
                do_acc[ch] = pend[ch] && (pend_edge[ch] == cycle);
            end
            // both ports see pre-edge contents
            for (int ch = 0; ch < 2; ch++) begin
                if (do_acc[ch]) begin
                    exp_old[ch] = model_mem[pend_req[ch].addr];
                end
            end
            // a goes first and b overwrites shared lanes
            for (int ch = 0; ch < 2; ch++) begin
                if (do_acc[ch] && pend_req[ch].we) begin
                    model_mem[pend_req[ch].addr] = merge_bytes(model_mem[pend_req[ch].addr],
                        pend_req[ch].wdata, pend_req[ch].wmask);
                end
                if (do_acc[ch]) begin
                    pend[ch] = 1'b0;
                end
            end
            for (int ch = 0; ch < 2; ch++) begin
                if (ack_of(ch) && !req[ch] && !req_seen[ch]) begin
                    proto_errors++;
                    $display("ERROR channel %s raised ack with no request", ch ? "b" : "a");
                end
                // fresh req is sampled next edge
                // ram access follows one edge later
                if (req[ch] && !req_seen[ch]) begin
                    pend[ch]      = 1'b1;
                    pend_edge[ch] = cycle + 2;
                    pend_req[ch]  = '{we[ch], addr[ch], wdata[ch], wmask[ch]};
                end
                req_seen[ch] = req[ch];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // requester
    ////////////////////////////////////////////////////////////

    // one full four-phase cycle
    // hold keeps req up after ack
    task automatic run_access(input int ch, input logic wr, input addr_t a, input word_t d,
                              input mask_t m, input int hold, input string name,
                              output word_t rd);
        int t_sample;
        int waited;
        @(posedge clk);
        req[ch]   <= 1'b1;
        we[ch]    <= wr;
        addr[ch]  <= a;
        wdata[ch] <= d;
        wmask[ch] <= m;
        @(negedge clk);
        t_sample = cycle + 1;
        waited   = 0;
        while (!ack_of(ch) && waited < 16) begin
            @(negedge clk);
            waited++;
        end
        if (!ack_of(ch)) begin
            proto_errors++;
            $display("ERROR %s: ack never rose", name);
        end
        check_latency({name, " latency"}, access_latency, cycle - t_sample);
        rd = rdata_of(ch);
        check_word({name, " rdata"}, exp_old[ch], rd);
        // ack and data must not move under back-pressure
        repeat (hold) begin
            @(negedge clk);
            if (!ack_of(ch)) begin
                proto_errors++;
                $display("ERROR %s: ack dropped while req was still held", name);
            end
            check_word({name, " held rdata"}, exp_old[ch], rdata_of(ch));
        end
        @(posedge clk);
        req[ch] <= 1'b0;
        @(negedge clk);
        if (!ack_of(ch)) begin
            proto_errors++;
            $display("ERROR %s: ack fell before req was seen low", name);
        end
        @(negedge clk);
        if (ack_of(ch)) begin
            proto_errors++;
            $display("ERROR %s: ack did not fall after req dropped", name);
        end
    endtask

    task automatic random_traffic(input int ch, input int count, input string name);
        int    gap;
        int    hold;
        logic  wr;
        addr_t a;
        word_t d;
        mask_t m;
        word_t rd;
        for (int i = 0; i < count; i++) begin
            gap  = $urandom_range(3);
            // now and then a long hold
            hold = ($urandom_range(7) == 0) ? $urandom_range(6, 3) : 0;
            // a quarter of the traffic hits four hot words
            a    = ($urandom_range(3) == 0) ? addr_t'($urandom_range(3)) : addr_t'($urandom);
            wr   = 1'($urandom_range(1));
            d    = $urandom;
            m    = mask_t'($urandom);
            repeat (gap) @(posedge clk);
            run_access(ch, wr, a, d, m, hold, name, rd);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        word_t rd;
        word_t rd_a;
        word_t rd_b;
        addr_t burst_addr;
        logic  bw [2];
        word_t bd [2];
        mask_t bm [2];
        void'($urandom(48311));
        rst = 1'b1;
        for (int ch = 0; ch < 2; ch++) begin
            req[ch]      = 1'b0;
            we[ch]       = 1'b0;
            addr[ch]     = '0;
            wdata[ch]    = '0;
            wmask[ch]    = '0;
            pend[ch]     = 1'b0;
            req_seen[ch] = 1'b0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // quiet outputs after reset
        repeat (3) begin
            @(negedge clk);
            if (a_ack !== 1'b0 || b_ack !== 1'b0) begin
                proto_errors++;
                $display("ERROR ack was not low after reset");
            end
        end

        // fill through b and read back through a
        for (int i = 0; i < mem_depth; i++) begin
            fill_data[i] = $urandom;
            run_access(1, 1'b1, addr_t'(i), fill_data[i], '1, 0, "fill write b", rd);
        end
        for (int i = 0; i < mem_depth; i++) begin
            run_access(0, 1'b0, addr_t'(i), '0, '0, 0, "fill read a", rd);
            check_word("fill data a", fill_data[i], rd);
        end

        // both channels at once
        fork
            random_traffic(0, n_random, "random a");
            random_traffic(1, n_random, "random b");
        join

        // lockstep bursts on one word
        for (int i = 0; i < n_burst; i++) begin
            burst_addr = addr_t'($urandom_range(3));
            for (int ch = 0; ch < 2; ch++) begin
                bw[ch] = 1'($urandom_range(1));
                bd[ch] = $urandom;
                bm[ch] = mask_t'($urandom);
            end
            fork
                run_access(0, bw[0], burst_addr, bd[0], bm[0], 0, "burst a", rd_a);
                run_access(1, bw[1], burst_addr, bd[1], bm[1], 0, "burst b", rd_b);
            join
        end

        // final sweep through b
        for (int i = 0; i < mem_depth; i++) begin
            run_access(1, 1'b0, addr_t'(i), '0, '0, 0, "sweep read b", rd);
        end

        $display("checks %0d, word errors %0d, latency errors %0d, protocol errors %0d",
                 checks, word_errors, latency_errors, proto_errors);
        if (word_errors + latency_errors + proto_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* source/soc_mem_top.sv */
`timescale 1ns/1ps

module soc_mem_top (
    input  logic               clk,
    input  logic               rst,

    // channel a, fetch and program load
    input  logic               a_req,
    input  logic               a_we,
    input  mem_bus_pkg::addr_t a_addr,
    input  mem_bus_pkg::word_t a_wdata,
    input  mem_bus_pkg::mask_t a_wmask,
    output logic               a_ack,
    output mem_bus_pkg::word_t a_rdata,

    // channel b, load/store data
    input  logic               b_req,
    input  logic               b_we,
    input  mem_bus_pkg::addr_t b_addr,
    input  mem_bus_pkg::word_t b_wdata,
    input  mem_bus_pkg::mask_t b_wmask,
    output logic               b_ack,
    output mem_bus_pkg::word_t b_rdata
);

    ////////////////////////////////////////////////////////////
    // controller to ram links
    ////////////////////////////////////////////////////////////

    mem_port_if mem_a ();
    mem_port_if mem_b ();

    // channel a controller
    req_ack_port port_a_ctrl (
        .clk   (clk),
        .rst   (rst),
        .req   (a_req),
        .we    (a_we),
        .addr  (a_addr),
        .wdata (a_wdata),
        .wmask (a_wmask),
        .ack   (a_ack),
        .rdata (a_rdata),
        .mem   (mem_a.ctrl)
    );

    // channel b controller
    req_ack_port port_b_ctrl (
        .clk   (clk),
        .rst   (rst),
        .req   (b_req),
        .we    (b_we),
        .addr  (b_addr),
        .wdata (b_wdata),
        .wmask (b_wmask),
        .ack   (b_ack),
        .rdata (b_rdata),
        .mem   (mem_b.ctrl)
    );

    ////////////////////////////////////////////////////////////
    // shared storage
    ////////////////////////////////////////////////////////////

    // b wins same-word byte collisions
    dualport_ram ram (
        .clk    (clk),
        .port_a (mem_a.ram),
        .port_b (mem_b.ram)
    );

endmodule

/* source/dualport_ram.sv */
`timescale 1ns/1ps

module dualport_ram (
    input  logic     clk,
    mem_port_if.ram  port_a,
    mem_port_if.ram  port_b
);

    import soc_cfg_pkg::*;
    import mem_bus_pkg::*;

    // storage, contents undefined after reset
    word_t mem [mem_depth];

    logic  wr_a;
    logic  wr_b;
    logic  same_word;
    mask_t be_a;
    mask_t be_b;

    ////////////////////////////////////////////////////////////
    // write enables and collision merge
    ////////////////////////////////////////////////////////////

    assign wr_a = port_a.en && port_a.we;
    assign wr_b = port_b.en && port_b.we;

    // both ports hitting one word this cycle
    assign same_word = (port_a.addr == port_b.addr);

    // port b bytes always go in
    assign be_b = wr_b ? port_b.wmask : '0;

    // port a loses any lane that port b also writes to the same word
    assign be_a = (wr_a ? port_a.wmask : '0) & ~(same_word ? be_b : '0);

    // lanes are disjoint after the merge
    // so the two writes never collide on a byte
    always_ff @(posedge clk) begin
        for (int i = 0; i < mask_width; i++) begin
            if (be_a[i]) begin
                mem[port_a.addr][i*byte_width +: byte_width] <=
                    port_a.wdata[i*byte_width +: byte_width];
            end
            if (be_b[i]) begin
                mem[port_b.addr][i*byte_width +: byte_width] <=
                    port_b.wdata[i*byte_width +: byte_width];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // registered reads
    ////////////////////////////////////////////////////////////

    // old contents on both ports, also for writes
    always_ff @(posedge clk) begin
        if (port_a.en) begin
            port_a.rdata <= mem[port_a.addr];
        end
    end

    always_ff @(posedge clk) begin
        if (port_b.en) begin
            port_b.rdata <= mem[port_b.addr];
        end
    end

endmodule

/* source/req_ack_port.sv */
`timescale 1ns/1ps

module req_ack_port (
    input  logic               clk,
    input  logic               rst,
    input  logic               req,
    input  logic               we,
    input  mem_bus_pkg::addr_t addr,
    input  mem_bus_pkg::word_t wdata,
    input  mem_bus_pkg::mask_t wmask,
    output logic               ack,
    output mem_bus_pkg::word_t rdata,
    mem_port_if.ctrl           mem
);

    import mem_bus_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_hold
    } state_t;

    state_t   state;
    logic     en_q;
    logic     new_req;
    mem_req_t req_q;

    ////////////////////////////////////////////////////////////
    // request detect and payload latch
    ////////////////////////////////////////////////////////////

    // only a fresh req while idle with ack low starts an access
    assign new_req = (state == st_idle) && req && !ack;

    always_ff @(posedge clk) begin
        if (new_req) begin
            req_q.we    <= we;
            req_q.addr  <= addr;
            req_q.wdata <= wdata;
            req_q.wmask <= wmask;
        end
    end

    ////////////////////////////////////////////////////////////
    // handshake fsm
    ////////////////////////////////////////////////////////////

    // access spans two cycles
    // first with en high, second waits on the ram read register
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            en_q  <= 1'b0;
            ack   <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (new_req) begin
                        state <= st_access;
                        en_q  <= 1'b1;
                    end
                end
                st_access: begin
                    if (en_q) begin
                        // ram does the access on this edge
                        en_q <= 1'b0;
                    end else begin
                        ack   <= 1'b1;
                        state <= st_hold;
                    end
                end
                st_hold: begin
                    // held req keeps ack up, no second access
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                    en_q  <= 1'b0;
                    ack   <= 1'b0;
                end
            endcase
        end
    end

    // read data capture, same edge that raises ack
    always_ff @(posedge clk) begin
        if (state == st_access && !en_q) begin
            rdata <= mem.rdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // ram port drive
    ////////////////////////////////////////////////////////////

    assign mem.en    = en_q;
    assign mem.we    = req_q.we;
    assign mem.addr  = req_q.addr;
    assign mem.wdata = req_q.wdata;
    assign mem.wmask = req_q.wmask;

endmodule

/* source/mem_port_if.sv */
`timescale 1ns/1ps

interface mem_port_if;

    import mem_bus_pkg::*;

    // one-cycle access strobe
    logic  en;
    // write when set, read only otherwise
    logic  we;
    addr_t addr;
    word_t wdata;
    mask_t wmask;
    // registered old word, valid the edge after en
    word_t rdata;

    // port controller side
    modport ctrl (
        output en, we, addr, wdata, wmask,
        input  rdata
    );

    // ram side
    modport ram (
        input  en, we, addr, wdata, wmask,
        output rdata
    );

endinterface

/* source/mem_bus_pkg.sv */
package mem_bus_pkg;

    import soc_cfg_pkg::*;

    ////////////////////////////////////////////////////////////
    // port payload types
    ////////////////////////////////////////////////////////////

    // one data word
    typedef logic [data_width-1:0] word_t;

    // byte write enables, bit i covers byte lane i
    typedef logic [mask_width-1:0] mask_t;

    // word address, not a byte address
    typedef logic [addr_width-1:0] addr_t;

    // request as latched by a port controller
    typedef struct packed {
        logic  we;
        addr_t addr;
        word_t wdata;
        mask_t wmask;
    } mem_req_t;

endpackage

/* source/soc_cfg_pkg.sv */
package soc_cfg_pkg;

    ////////////////////////////////////////////////////////////
    // word geometry
    ////////////////////////////////////////////////////////////

    // bits per data word
    localparam int data_width = 32;

    // bits per byte lane
    localparam int byte_width = 8;

    // one write enable per byte lane
    localparam int mask_width = data_width / byte_width;

    ////////////////////////////////////////////////////////////
    // storage and timing
    ////////////////////////////////////////////////////////////

    // words held by the on-chip ram
    localparam int mem_depth  = 256;
    localparam int addr_width = $clog2(mem_depth);

    // req sample edge to ack rise edge, in clocks
    localparam int access_latency = 2;

endpackage
